/* src/spif_params.svh */
// ================================================
// shared sizes and boot constants for the flash boot loader
// code words are 16 bits and data words are SPIF_WIDTH bits
// ================================================
`ifndef SPIF_PARAMS_SVH
`define SPIF_PARAMS_SVH

// ================================================
// word and RAM geometry
// ================================================
`define SPIF_WIDTH      18      // data word width
`define SPIF_CODE_AW    10      // code RAM address bits
`define SPIF_DATA_AW    10      // data RAM address bits
`define SPIF_CODE_W     16      // code word width

// ================================================
// flash boot constants
// ================================================
`define SPIF_BASEBLOCK  8'h00   // first 64KB sector of the boot image
`define SPIF_FAST_READ  8'h0B   // fast read opcode
`define SPIF_RATE_INIT  4'd7    // SCLK divisor out of reset

`endif

/* src/spif_pkg.sv */
// ================================================
// boot record byte views and the RAM write target
// ================================================
package spif_pkg;

  typedef enum logic [1:0] {
    KIND_DATA0 = 2'b00,             // data mode
    KIND_DATA1 = 2'b01,             // data mode too
    KIND_RATE  = 2'b10,             // new SCLK divisor
    KIND_CTL   = 2'b11              // prefix load or end of boot
  } cmd_kind_e;

  typedef enum logic {
    TGT_CODE = 1'b0,
    TGT_DATA = 1'b1
  } wr_target_e;

  typedef struct packed {
    cmd_kind_e   kind;
    logic [5:0]  arg;               // low nibble is the rate divisor
  } cmd_hdr_t;

  typedef struct packed {
    cmd_kind_e   kind;
    logic        end_boot;          // 1 ends the boot
    logic        rst_val;           // processor reset after the boot
    logic [1:0]  unused;
    logic        sel_len;           // 1 loads count, 0 loads destination
    logic        two_byte;          // high byte comes first
  } cmd_ctl_t;

  typedef struct packed {
    cmd_kind_e   kind;
    logic        unused;
    logic [2:0]  sink;              // 0 code, 1 data, others dropped
    logic [1:0]  bpw_m1;            // bytes per word minus one
  } cmd_dat_t;

  typedef union packed {
    cmd_hdr_t hdr;
    cmd_ctl_t ctl;
    cmd_dat_t dat;
  } boot_cmd_t;

endpackage

/* src/spif_boot_reader.sv */
`timescale 1ns/1ps
// ================================================
// one flash transfer in flight at a time; a reboot is taken only after booting ends
// words keep their low SPIF_WIDTH bits and sinks above 1 are counted but not written
// ================================================
`include "spif_params.svh"

module spif_boot_reader (
  input  logic                    clk,
  input  logic                    arstn,         // async reset, active low
  input  logic                    i_reboot,      // one-cycle restart request
  input  logic                    i_f_ready,     // flash takes a byte
  input  logic                    i_f_rx_valid,  // flash answer strobe
  input  logic [7:0]              i_f_din,       // flash answer byte
  input  logic                    i_bw_ready,
  output logic                    o_f_valid,
  output logic [7:0]              o_f_dout,
  output logic [2:0]              o_f_format,    // 0 raises CS#
  output logic [3:0]              o_f_rate,      // SCLK divisor
  output logic                    o_bw_valid,
  output spif_pkg::wr_target_e    o_bw_target,
  output logic [15:0]             o_bw_addr,     // destination pointer
  output logic [`SPIF_WIDTH-1:0]  o_bw_data,     // assembled word
  output logic                    o_booting,
  output logic                    o_p_reset,
  output logic [7:0]              o_last_byte
);
  import spif_pkg::*;

  localparam logic [2:0] HDR_LEN  = 3'd5;    // opcode, 3 address bytes, dummy
  localparam logic [2:0] FMT_READ = 3'b010;  // single rate, CS# low
  localparam logic [3:0] MODE_CMD = 4'b0000;

  logic        f_busy;       // byte accepted, answer pending
  logic [2:0]  hdr_cnt;      // preamble bytes answered
  logic [3:0]  mode;         // 00xx cmd, 010h dest, 011h count, 1sss data
  logic [15:0] count;        // words left minus one
  logic [1:0]  bpw;          // bytes per word minus one
  logic [1:0]  bytecnt;      // bytes left in this word
  boot_cmd_t   cmd;
  logic        f_fire;
  logic        bw_fire;
  logic        rx_rec;       // answer is a record byte
  logic        first_byte;

  assign cmd        = i_f_din;
  assign f_fire     = o_f_valid & i_f_ready;
  assign bw_fire    = o_bw_valid & i_bw_ready;
  assign rx_rec     = i_f_rx_valid & (hdr_cnt == HDR_LEN);
  assign first_byte = (bytecnt == bpw);

  always_comb begin                              // byte to send
    case (hdr_cnt)
      3'd0:    o_f_dout = `SPIF_FAST_READ;
      3'd1:    o_f_dout = `SPIF_BASEBLOCK;
      default: o_f_dout = 8'h00;                 // address lsbs, dummy, clock-in
    endcase
  end

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_booting   <= 1'b1;
      o_p_reset   <= 1'b1;
      o_f_valid   <= 1'b0;
      o_f_format  <= 3'd0;
      o_f_rate    <= `SPIF_RATE_INIT;
      f_busy      <= 1'b0;
      hdr_cnt     <= 3'd0;
      mode        <= MODE_CMD;
      count       <= 16'd0;
      bpw         <= 2'd0;
      bytecnt     <= 2'd0;
      o_bw_addr   <= 16'd0;
      o_bw_valid  <= 1'b0;
      o_bw_target <= TGT_CODE;
    end else begin
      // ================================================
      // flash transfers
      // ================================================
      if (f_fire) begin
        o_f_valid <= 1'b0;
        f_busy    <= 1'b1;
      end else if (o_booting && !o_f_valid && !f_busy && !o_bw_valid) begin
        o_f_valid  <= 1'b1;                      // no fetch while a write waits
        o_f_format <= FMT_READ;
      end
      if (i_f_rx_valid) begin
        f_busy <= 1'b0;
        if (hdr_cnt != HDR_LEN)
          hdr_cnt <= hdr_cnt + 3'd1;             // preamble answers are dropped
      end
      if (bw_fire) begin
        o_bw_valid <= 1'b0;
        o_bw_addr  <= o_bw_addr + 16'd1;         // bump after the write lands
      end
      // ================================================
      // record interpreter
      // ================================================
      if (rx_rec) begin
        if (mode[3]) begin                       // data byte
          if (bytecnt != 2'd0) begin
            bytecnt <= bytecnt - 2'd1;
          end else begin
            bytecnt <= bpw;
            if (mode[2:1] == 2'b00) begin        // code or data sink
              o_bw_valid  <= 1'b1;
              o_bw_target <= mode[0] ? TGT_DATA : TGT_CODE;
            end else begin
              o_bw_addr <= o_bw_addr + 16'd1;    // dropped word still advances
            end
            if (count != 16'd0)
              count <= count - 16'd1;
            else
              mode <= MODE_CMD;                  // last word of the run
          end
        end else if (mode[2]) begin              // prefix byte
          if (mode[1]) begin
            if (mode[0])
              count[15:8] <= i_f_din;
            else
              count[7:0] <= i_f_din;
          end else begin
            if (mode[0])
              o_bw_addr[15:8] <= i_f_din;
            else
              o_bw_addr[7:0] <= i_f_din;
          end
          mode <= mode[0] ? {mode[3:1], 1'b0} : MODE_CMD;
        end else begin                           // command byte
          case (cmd.hdr.kind)
            KIND_CTL: begin
              if (cmd.ctl.end_boot) begin
                o_booting  <= 1'b0;
                o_f_format <= 3'd0;              // raise CS#
                o_p_reset  <= cmd.ctl.rst_val;
              end else begin
                mode <= {2'b01, cmd.ctl.sel_len, cmd.ctl.two_byte};
              end
            end
            KIND_RATE: o_f_rate <= cmd.hdr.arg[3:0];
            default: begin                       // enter data mode
              mode    <= {1'b1, cmd.dat.sink};
              bpw     <= cmd.dat.bpw_m1;
              bytecnt <= cmd.dat.bpw_m1;
            end
          endcase
        end
      end
      if (i_reboot && !o_booting) begin          // restart with the preamble
        o_booting <= 1'b1;
        hdr_cnt   <= 3'd0;
        mode      <= MODE_CMD;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_f_rx_valid)
      o_last_byte <= i_f_din;
    if (rx_rec && mode[3]) begin                 // big-endian shift
      if (first_byte)
        o_bw_data <= {{(`SPIF_WIDTH-8){1'b0}}, i_f_din};
      else
        o_bw_data <= {o_bw_data[`SPIF_WIDTH-9:0], i_f_din};
    end
  end

endmodule

/* src/spif_io_regs.sv */
`timescale 1ns/1ps
// ================================================
// registers live at I/O addresses 0 to 15; writes are ignored while p_hold is high
// ================================================
`include "spif_params.svh"

module spif_io_regs (
  input  logic                      clk,
  input  logic                      arstn,        // async reset, active low
  input  logic                      i_io_rd,
  input  logic                      i_io_wr,
  input  logic [14:0]               i_addr,
  input  logic [`SPIF_WIDTH-1:0]    i_din,
  input  logic                      i_p_hold,
  input  logic                      i_booting,
  input  logic [7:0]                i_last_byte,
  input  logic                      i_cw_ready,
  output logic [`SPIF_WIDTH-1:0]    o_io_dout,
  output logic                      o_cw_valid,   // code write pending
  output logic [`SPIF_CODE_AW-1:0]  o_cw_addr,    // auto-incrementing
  output logic [`SPIF_CODE_W-1:0]   o_cw_data,
  output logic                      o_reboot      // one-cycle strobe
);

  localparam logic [3:0] REG_CODE_ADDR = 4'h1;
  localparam logic [3:0] REG_CODE_DATA = 4'h2;
  localparam logic [3:0] REG_BOOT      = 4'h3;    // write reboots, read last byte
  localparam logic [3:0] REG_STATUS    = 4'h5;
  localparam logic [3:0] REG_GENERAL   = 4'h8;

  logic                    internal;
  logic                    wr_ok;
  logic [`SPIF_WIDTH-1:0]  gen_word;              // general purpose word
  logic [`SPIF_WIDTH-1:0]  rd_word;

  assign internal = (i_addr[14:4] == 11'd0);
  assign wr_ok    = i_io_wr & internal & ~i_p_hold;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_cw_valid <= 1'b0;
      o_cw_addr  <= '0;
      o_reboot   <= 1'b0;
      gen_word   <= '0;
    end else begin
      o_reboot <= 1'b0;
      if (o_cw_valid && i_cw_ready) begin
        o_cw_valid <= 1'b0;
        o_cw_addr  <= o_cw_addr + 1'b1;             // next code word
      end
      if (wr_ok) begin
        case (i_addr[3:0])
          REG_CODE_ADDR: o_cw_addr  <= i_din[`SPIF_CODE_AW-1:0];
          REG_CODE_DATA: o_cw_valid <= 1'b1;
          REG_BOOT:      o_reboot   <= 1'b1;
          REG_GENERAL:   gen_word   <= i_din;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok && (i_addr[3:0] == REG_CODE_DATA))
      o_cw_data <= i_din[`SPIF_CODE_W-1:0];
  end

  always_comb begin                               // read mux
    rd_word = gen_word;
    if (internal) begin
      case (i_addr[3:0])
        REG_CODE_DATA: rd_word = {{(`SPIF_WIDTH-1){1'b0}}, o_cw_valid};
        REG_BOOT:      rd_word = {{(`SPIF_WIDTH-8){1'b0}}, i_last_byte};
        REG_STATUS:    rd_word = {{(`SPIF_WIDTH-1){1'b0}}, i_booting};
        default: ;
      endcase
    end
  end

  assign o_io_dout = i_io_rd ? rd_word : '0;

endmodule

/* src/spif_mem_arbiter.sv */
`timescale 1ns/1ps
// ================================================
// purely combinational; boot code beats CPU code and CPU data beats boot data
// ================================================
`include "spif_params.svh"

module spif_mem_arbiter (
  input  logic                      i_bw_valid,
  input  spif_pkg::wr_target_e      i_bw_target,
  input  logic [15:0]               i_bw_addr,
  input  logic [`SPIF_WIDTH-1:0]    i_bw_data,
  input  logic                      i_cw_valid,
  input  logic [`SPIF_CODE_AW-1:0]  i_cw_addr,
  input  logic [`SPIF_CODE_W-1:0]   i_cw_data,
  input  logic [14:0]               i_code_addr,  // CPU fetch address
  input  logic                      i_mem_rd,
  input  logic                      i_mem_wr,
  input  logic [14:0]               i_mem_addr,
  input  logic [`SPIF_WIDTH-1:0]    i_din,
  input  logic                      i_io_busy,    // CPU code write pending
  output logic                      o_bw_ready,
  output logic                      o_cw_ready,
  output logic [`SPIF_CODE_AW-1:0]  o_code_a,
  output logic [`SPIF_CODE_W-1:0]   o_code_din,
  output logic                      o_code_wr,
  output logic                      o_code_rd,
  output logic [`SPIF_DATA_AW-1:0]  o_data_a,
  output logic [`SPIF_WIDTH-1:0]    o_data_din,
  output logic                      o_data_wr,
  output logic                      o_data_rd,
  output logic                      o_p_hold
);
  import spif_pkg::*;

  logic boot_code;    // boot code write, always wins
  logic boot_data;    // boot data write request
  logic boot_dwr;     // boot data write granted
  logic cpu_cwr;      // CPU code write granted

  assign boot_code = i_bw_valid & (i_bw_target == TGT_CODE);
  assign boot_data = i_bw_valid & (i_bw_target == TGT_DATA);
  assign boot_dwr  = boot_data & ~i_mem_wr;
  assign cpu_cwr   = i_cw_valid & ~boot_code;

  assign o_bw_ready = ~((i_bw_target == TGT_DATA) & i_mem_wr);
  assign o_cw_ready = ~boot_code;

  // ================================================
  // code RAM port
  // ================================================
  assign o_code_wr  = boot_code | cpu_cwr;
  assign o_code_a   = boot_code ? i_bw_addr[`SPIF_CODE_AW-1:0] :
                      cpu_cwr   ? i_cw_addr : i_code_addr[`SPIF_CODE_AW-1:0];
  assign o_code_din = boot_code ? i_bw_data[`SPIF_CODE_W-1:0] : i_cw_data;

  // ================================================
  // data RAM port
  // ================================================
  assign o_data_wr  = i_mem_wr | boot_dwr;
  assign o_data_a   = boot_dwr ? i_bw_addr[`SPIF_DATA_AW-1:0] :
                      i_mem_addr[`SPIF_DATA_AW-1:0];
  assign o_data_din = boot_dwr ? i_bw_data : i_din;

  // hold keeps CPU reads in step while the ports are borrowed
  assign o_p_hold  = boot_code | boot_dwr | i_io_busy;
  assign o_code_rd = ~o_p_hold;
  assign o_data_rd = i_mem_rd & ~o_p_hold;

endmodule

/* src/spif.sv */
`timescale 1ns/1ps
// ================================================
// flash must answer each accepted byte with one rx strobe; RAMs are external
// ================================================
`include "spif_params.svh"

module spif (
  input  logic                      clk,
  input  logic                      arstn,        // async reset, active low
  // CPU bus
  input  logic                      i_io_rd,
  input  logic                      i_io_wr,
  input  logic                      i_mem_rd,
  input  logic                      i_mem_wr,
  input  logic [14:0]               i_mem_addr,
  input  logic [`SPIF_WIDTH-1:0]    i_din,
  output logic [`SPIF_WIDTH-1:0]    o_io_dout,
  input  logic [14:0]               i_code_addr,
  output logic                      o_p_hold,
  output logic                      o_p_reset,
  // RAM ports
  output logic [`SPIF_DATA_AW-1:0]  o_data_a,
  output logic [`SPIF_WIDTH-1:0]    o_data_din,
  output logic                      o_data_wr,
  output logic                      o_data_rd,
  output logic [`SPIF_CODE_AW-1:0]  o_code_a,
  output logic [`SPIF_CODE_W-1:0]   o_code_din,
  output logic                      o_code_wr,
  output logic                      o_code_rd,
  // flash byte channel
  input  logic                      i_f_ready,
  output logic                      o_f_valid,
  output logic [7:0]                o_f_dout,
  output logic [2:0]                o_f_format,
  output logic [3:0]                o_f_rate,
  input  logic                      i_f_rx_valid,
  input  logic [7:0]                i_f_din
);
  import spif_pkg::*;

  logic                      reboot;
  logic                      booting;
  logic [7:0]                last_byte;
  logic                      bw_valid;
  logic                      bw_ready;
  wr_target_e                bw_target;
  logic [15:0]               bw_addr;
  logic [`SPIF_WIDTH-1:0]    bw_data;
  logic                      cw_valid;
  logic                      cw_ready;
  logic [`SPIF_CODE_AW-1:0]  cw_addr;
  logic [`SPIF_CODE_W-1:0]   cw_data;

  spif_boot_reader u_reader (
    .clk          (clk),
    .arstn        (arstn),
    .i_reboot     (reboot),
    .i_f_ready    (i_f_ready),
    .i_f_rx_valid (i_f_rx_valid),
    .i_f_din      (i_f_din),
    .i_bw_ready   (bw_ready),
    .o_f_valid    (o_f_valid),
    .o_f_dout     (o_f_dout),
    .o_f_format   (o_f_format),
    .o_f_rate     (o_f_rate),
    .o_bw_valid   (bw_valid),
    .o_bw_target  (bw_target),
    .o_bw_addr    (bw_addr),
    .o_bw_data    (bw_data),
    .o_booting    (booting),
    .o_p_reset    (o_p_reset),
    .o_last_byte  (last_byte)
  );

  spif_io_regs u_regs (
    .clk          (clk),
    .arstn        (arstn),
    .i_io_rd      (i_io_rd),
    .i_io_wr      (i_io_wr),
    .i_addr       (i_mem_addr),                   // I/O shares the data address
    .i_din        (i_din),
    .i_p_hold     (o_p_hold),
    .i_booting    (booting),
    .i_last_byte  (last_byte),
    .i_cw_ready   (cw_ready),
    .o_io_dout    (o_io_dout),
    .o_cw_valid   (cw_valid),
    .o_cw_addr    (cw_addr),
    .o_cw_data    (cw_data),
    .o_reboot     (reboot)
  );

  spif_mem_arbiter u_arb (
    .i_bw_valid   (bw_valid),
    .i_bw_target  (bw_target),
    .i_bw_addr    (bw_addr),
    .i_bw_data    (bw_data),
    .i_cw_valid   (cw_valid),
    .i_cw_addr    (cw_addr),
    .i_cw_data    (cw_data),
    .i_code_addr  (i_code_addr),
    .i_mem_rd     (i_mem_rd),
    .i_mem_wr     (i_mem_wr),
    .i_mem_addr   (i_mem_addr),
    .i_din        (i_din),
    .i_io_busy    (cw_valid),                     // pending code write holds CPU
    .o_bw_ready   (bw_ready),
    .o_cw_ready   (cw_ready),
    .o_code_a     (o_code_a),
    .o_code_din   (o_code_din),
    .o_code_wr    (o_code_wr),
    .o_code_rd    (o_code_rd),
    .o_data_a     (o_data_a),
    .o_data_din   (o_data_din),
    .o_data_wr    (o_data_wr),
    .o_data_rd    (o_data_rd),
    .o_p_hold     (o_p_hold)
  );

endmodule

/* testbench/spif_flash_model.sv */
`timescale 1ns/1ps
// ================================================
// one transfer in flight; the 5 preamble bytes are answered with 0xFF
// record bytes come from the cases file, starting at word i_img_base
// ================================================

module spif_flash_model (
  input  logic        clk,
  input  logic        arstn,
  input  logic        i_valid,       // DUT byte offered
  input  logic [7:0]  i_byte,
  input  logic [2:0]  i_format,      // 0 means CS# high
  input  int          i_img_base,    // first image word of the current case
  output logic        o_ready,
  output logic        o_rx_valid,
  output logic [7:0]  o_rx_byte
);

  localparam int HDR_LEN = 5;          // opcode, 3 address bytes, dummy

  logic [31:0] img_mem [0:255];      // whole cases file
  logic [7:0]  log_mem [0:255];      // bytes accepted in the current read
  int          n_log;                // accepted so far in this read
  logic        fresh;                // next byte opens a new read
  int          delay_cnt;            // cycles until the answer
  logic [7:0]  answer;
  int          pos;

  initial begin
    $readmemh("testbench/spif_cases.txt", img_mem);
    o_ready    = 1'b0;
    o_rx_valid = 1'b0;
    o_rx_byte  = 8'h00;
  end

  always @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_ready    <= 1'b0;
      o_rx_valid <= 1'b0;
      o_rx_byte  <= 8'h00;
      n_log      <= 0;
      fresh      <= 1'b1;
      delay_cnt  <= 0;
      answer     <= 8'h00;
    end else begin
      o_ready    <= ($urandom % 4) != 0;   // stall about one cycle in four
      o_rx_valid <= 1'b0;
      if (i_format == 3'd0)
        fresh <= 1'b1;                     // CS# high ends the read
      if (delay_cnt == 1) begin
        o_rx_valid <= 1'b1;
        o_rx_byte  <= answer;
      end
      if (delay_cnt != 0)
        delay_cnt <= delay_cnt - 1;
      if (i_valid && o_ready) begin
        pos = fresh ? 0 : n_log;
        log_mem[pos] <= i_byte;
        n_log        <= pos + 1;
        fresh        <= 1'b0;
        if (pos < HDR_LEN)
          answer <= 8'hFF;                 // reader drops these
        else
          answer <= img_mem[i_img_base + pos - HDR_LEN][7:0];
        delay_cnt <= 1 + ($urandom % 3);   // answer after 1 to 3 cycles
      end
    end
  end

endmodule

/* testbench/spif_tb.sv */
`timescale 1ns/1ps
// ================================================
// cases are read from testbench/spif_cases.txt relative to the project root
// boot end is seen as o_f_format returning to 0
// ================================================
`include "spif_params.svh"

module spif_tb;

  localparam int         CLK_HALF   = 10;      // 20 ns period
  localparam int         HDR_LEN    = 5;
  localparam logic [7:0] FAST_READ  = 8'h0B;
  localparam logic [7:0] BASE_BLOCK = 8'h00;

  logic                      clk;
  logic                      arstn;
  logic                      i_io_rd;
  logic                      i_io_wr;
  logic                      i_mem_rd;
  logic                      i_mem_wr;
  logic [14:0]               i_mem_addr;
  logic [`SPIF_WIDTH-1:0]    i_din;
  logic [14:0]               i_code_addr;
  logic [`SPIF_WIDTH-1:0]    o_io_dout;
  logic                      o_p_hold;
  logic                      o_p_reset;
  logic [`SPIF_DATA_AW-1:0]  o_data_a;
  logic [`SPIF_WIDTH-1:0]    o_data_din;
  logic                      o_data_wr;
  logic                      o_data_rd;
  logic [`SPIF_CODE_AW-1:0]  o_code_a;
  logic [`SPIF_CODE_W-1:0]   o_code_din;
  logic                      o_code_wr;
  logic                      o_code_rd;
  logic                      f_ready;
  logic                      o_f_valid;
  logic [7:0]                o_f_dout;
  logic [2:0]                o_f_format;
  logic [3:0]                o_f_rate;
  logic                      f_rx_valid;
  logic [7:0]                f_din;
  int                        img_base;

  logic [31:0]             cases_mem [0:255];
  logic [`SPIF_CODE_W-1:0] code_ram  [0:1023];
  logic                    code_hit  [0:1023];   // written in this case
  logic [`SPIF_WIDTH-1:0]  data_ram  [0:1023];
  logic                    data_hit  [0:1023];
  int                      errors;
  int                      checks;
  int                      n_pass;
  int                      n_fail;
  int                      limit_cycles;

  spif i_dut (
    .clk (clk), .arstn (arstn),
    .i_io_rd (i_io_rd), .i_io_wr (i_io_wr), .i_mem_rd (i_mem_rd), .i_mem_wr (i_mem_wr),
    .i_mem_addr (i_mem_addr), .i_din (i_din), .o_io_dout (o_io_dout),
    .i_code_addr (i_code_addr), .o_p_hold (o_p_hold), .o_p_reset (o_p_reset),
    .o_data_a (o_data_a), .o_data_din (o_data_din), .o_data_wr (o_data_wr),
    .o_data_rd (o_data_rd), .o_code_a (o_code_a), .o_code_din (o_code_din),
    .o_code_wr (o_code_wr), .o_code_rd (o_code_rd),
    .i_f_ready (f_ready), .o_f_valid (o_f_valid), .o_f_dout (o_f_dout),
    .o_f_format (o_f_format), .o_f_rate (o_f_rate),
    .i_f_rx_valid (f_rx_valid), .i_f_din (f_din)
  );

  spif_flash_model u_flash (
    .clk (clk), .arstn (arstn), .i_valid (o_f_valid), .i_byte (o_f_dout),
    .i_format (o_f_format), .i_img_base (img_base),
    .o_ready (f_ready), .o_rx_valid (f_rx_valid), .o_rx_byte (f_din)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  always @(posedge clk) begin                    // RAM models
    if (arstn && o_code_wr) begin
      code_ram[o_code_a] <= o_code_din;
      code_hit[o_code_a] <= 1'b1;
    end
    if (arstn && o_data_wr) begin
      data_ram[o_data_a] <= o_data_din;
      data_hit[o_data_a] <= 1'b1;
    end
  end

  // ================================================
  // checks
  // ================================================
  task automatic check_value(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("ERROR at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic check_ram(input logic is_data, inout int p);
    int          n;
    int          i;
    int          a;
    int          hits;
    logic [31:0] want;
    string       ram;
    ram  = is_data ? "data_ram" : "code_ram";
    n    = cases_mem[p];
    p    = p + 1;
    hits = 0;
    for (a = 0; a < 1024; a++)
      if (is_data ? data_hit[a] : code_hit[a])
        hits++;
    check_flag(hits == n, $sformatf("%s has %0d written addresses, %0d expected", ram, hits, n));
    for (i = 0; i < n; i++) begin
      a    = cases_mem[p];
      want = cases_mem[p + 1];
      p    = p + 2;
      check_flag(is_data ? data_hit[a] : code_hit[a],
                 $sformatf("%s[0x%03h] was never written", ram, a));
      check_value($sformatf("%s[0x%03h]", ram, a), is_data ? data_ram[a] : code_ram[a], want);
    end
  endtask

  always @(posedge clk) begin                    // hold and read gating monitor
    if (arstn) begin
      if (o_code_wr)
        check_flag(o_p_hold, "code RAM written while the processor was not held");
      if (o_data_wr && !i_mem_wr)
        check_flag(o_p_hold, "boot data write while the processor was not held");
      if (o_p_hold)
        check_flag(!o_code_rd && !o_data_rd, "RAM read enabled during a processor hold");
      else
        check_flag(o_code_rd && (o_data_rd == i_mem_rd),
                   "RAM read enables do not follow the CPU without a hold");
    end
  end

  // ================================================
  // CPU bus and helpers
  // ================================================
  task automatic io_write(input logic [3:0] reg_sel, input logic [`SPIF_WIDTH-1:0] value);
    logic taken;
    taken = 1'b0;
    @(posedge clk);
    i_io_wr    <= 1'b1;
    i_mem_addr <= {11'd0, reg_sel};
    i_din      <= value;
    while (!taken) begin
      @(posedge clk);
      taken = !o_p_hold;                         // retried while held
    end
    i_io_wr <= 1'b0;
  endtask

  task automatic io_read(input logic [3:0] reg_sel, output logic [`SPIF_WIDTH-1:0] value);
    @(posedge clk);
    i_io_rd    <= 1'b1;
    i_mem_addr <= {11'd0, reg_sel};
    @(posedge clk);
    value   = o_io_dout;                         // settled during the last cycle
    i_io_rd <= 1'b0;
  endtask

  task automatic mem_write(input logic [14:0] addr, input logic [`SPIF_WIDTH-1:0] value,
                           input int cycles);
    @(posedge clk);
    i_mem_wr   <= 1'b1;
    i_mem_addr <= addr;
    i_din      <= value;
    repeat (cycles) @(posedge clk);            // same word held for the burst
    i_mem_wr <= 1'b0;
  endtask

  task automatic wait_format(input logic active);
    @(posedge clk);
    while ((o_f_format != 3'd0) != active)
      @(posedge clk);
  endtask

  task automatic clear_hits();
    int a;
    for (a = 0; a < 1024; a++) begin
      code_hit[a] = 1'b0;
      data_hit[a] = 1'b0;
    end
  endtask

  function automatic int run_limit(input int n_cases);
    int p;
    int c;
    int total;
    p     = 1;
    total = 0;
    for (c = 0; c < n_cases; c++) begin
      total = total + cases_mem[p];
      p     = p + 1 + cases_mem[p];              // image
      p     = p + 1 + 2 * cases_mem[p];          // CPU ops
      p     = p + 1 + 2 * cases_mem[p];          // code list
      p     = p + 1 + 2 * cases_mem[p];          // data list
      p     = p + 2;                             // rate, p_reset
    end
    return total * 40 + n_cases * 400 + 100;
  endfunction

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("TIMEOUT: run did not finish within %0d cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ================================================
  // case sequence
  // ================================================
  initial begin : main
    int                      seed;
    int                      n_cases;
    int                      p;
    int                      c;
    int                      k;
    int                      n;
    int                      img_len;
    int                      errs_at_start;
    logic [31:0]             op_a;
    logic [31:0]             op_b;
    logic [7:0]              last_byte;
    logic [`SPIF_WIDTH-1:0]  rd;
    seed        = $urandom(32'hd69a);
    arstn       = 1'b0;
    i_io_rd     = 1'b0;
    i_io_wr     = 1'b0;
    i_mem_rd    = 1'b0;
    i_mem_wr    = 1'b0;
    i_mem_addr  = '0;
    i_din       = '0;
    i_code_addr = '0;
    img_base    = 0;
    $readmemh("testbench/spif_cases.txt", cases_mem);
    n_cases      = cases_mem[0];
    limit_cycles = run_limit(n_cases);
    repeat (16) @(posedge clk);
    arstn <= 1'b1;
    p = 1;
    for (c = 0; c < n_cases; c++) begin
      errs_at_start = errors;
      clear_hits();
      img_len   = cases_mem[p];
      img_base  = p + 1;
      last_byte = cases_mem[p + img_len][7:0];   // the end record
      p         = p + 1 + img_len;
      if (c != 0)
        io_write(4'h3, '0);                      // reboot
      wait_format(1'b1);
      i_mem_rd <= 1'b1;                          // CPU reads data RAM during the boot
      if (c == 0)
        check_value("o_p_reset", o_p_reset, 1);
      io_read(4'h5, rd);
      check_value("booting", rd, 1);
      n = cases_mem[p];
      p = p + 1;
      for (k = 0; k < n; k++) begin
        op_a = cases_mem[p];
        op_b = cases_mem[p + 1];
        p    = p + 2;
        repeat (op_a[27:16]) @(posedge clk);
        if (op_a[31:28] == 4'd1)
          io_write(op_a[3:0], op_b[`SPIF_WIDTH-1:0]);
        else
          mem_write(op_a[14:0], op_b[`SPIF_WIDTH-1:0], op_b[31:24]);
      end
      wait_format(1'b0);                         // end record taken
      i_mem_rd <= 1'b0;
      @(posedge clk);
      while (o_p_hold)
        @(posedge clk);
      check_value("flash byte 0", u_flash.log_mem[0], FAST_READ);
      check_value("flash byte 1", u_flash.log_mem[1], BASE_BLOCK);
      check_value("flash byte 2", u_flash.log_mem[2], 0);
      check_value("flash byte 3", u_flash.log_mem[3], 0);
      check_value("flash bytes accepted", u_flash.n_log, HDR_LEN + img_len);
      io_read(4'h5, rd);
      check_value("booting", rd, 0);
      io_read(4'h3, rd);
      check_value("last flash byte", rd, last_byte);
      check_ram(1'b0, p);
      check_ram(1'b1, p);
      check_value("o_f_rate", o_f_rate, cases_mem[p]);
      check_value("o_p_reset", o_p_reset, cases_mem[p + 1]);
      p = p + 2;
      if (errors == errs_at_start) begin
        n_pass++;
        $display("case %0d: pass", c);
      end else begin
        n_fail++;
        $display("case %0d: FAIL with %0d errors", c, errors - errs_at_start);
      end
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             n_cases, n_pass, n_fail, checks, errors);
    if (errors == 0 && n_fail == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* spif.f */
+incdir+src
src/spif_pkg.sv
src/spif_boot_reader.sv
src/spif_io_regs.sv
src/spif_mem_arbiter.sv
src/spif.sv
testbench/spif_flash_model.sv
testbench/spif_tb.sv

/* Bender.yml */
package:
  name: spif

sources:
  - include_dirs:
      - src
    files:
      - src/spif_pkg.sv
      - src/spif_boot_reader.sv
      - src/spif_io_regs.sv
      - src/spif_mem_arbiter.sv
      - src/spif.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/spif_flash_model.sv
      - testbench/spif_tb.sv

/* testbench/spif_cases.txt */
// per case: image length, image bytes, op count, ops, code count, code addr/value,
// data count, data addr/value, rate, p_reset. op = {kind,delay,addr} {cycles,value}
3
// case 0: code record after reset, rate 3, end with reset 0
0F
C1 00 10 C3 00 02 01 12 34 AB CD 00 FF 83 E0
0
3 010 1234 011 ABCD 012 00FF
0
3 0
// case 1: 24-bit data words, a sink 2 record, CPU data writes during boot
1E
C1 00 20 C3 00 03 06
01 23 45 FF FF FF 02 00 01 5A A5 3C
C1 00 40 C3 00 01 08 77 88 85 F0
2
201E0100 5002BEEF
20010101 01015A5A
0
6 020 12345 021 3FFFF 022 20001 023 2A53C 100 2BEEF 101 15A5A
5 1
// case 2: one boot code word, CPU code loading through registers 1 and 2
0B
C1 00 30 C3 00 00 01 BE EF 8A E0
4
10050001 00000200
10010002 00001111
10010002 00002222
10010002 00003333
4 030 BEEF 200 1111 201 2222 202 3333
0
A 0
